//--- Makefile
VERILATOR ?= verilator
TOP       ?= cnn_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
logic/cnn_pkg.sv
logic/row_parallelize.sv
logic/row_counter.sv
logic/conv_sequencer.sv
logic/conv_row_layer.sv
logic/max_pool_row.sv
logic/row_serialize.sv
logic/cnn_top.sv
verif/cnn_assertions.sv
verif/cnn_tb.sv

//--- logic/cnn_pkg.sv
// Shared sizes, kernel weights, row types and sequencer states for the CNN pipeline and its testbench
package cnn_pkg;

    // Image geometry
    localparam int IMG_WIDTH      = 8;
    localparam int PIXEL_BITS     = 8;
    localparam int OUT_CHANNELS   = 2;
    localparam int POOL_WIDTH     = IMG_WIDTH / 2;
    localparam int WEIGHT_Q_SHIFT = 6;

    // Indexed [channel][kernel row][kernel column], row 0 is the row above
    localparam logic signed [7:0] KERNEL_WEIGHTS [OUT_CHANNELS][3][3] = '{
        // Box filter, window sum / 16
        '{'{8'sd4, 8'sd4, 8'sd4}, '{8'sd4, 8'sd4, 8'sd4}, '{8'sd4, 8'sd4, 8'sd4}},
        // Vertical edge, above minus below
        '{'{8'sd0, 8'sd64, 8'sd0}, '{8'sd0, 8'sd0, 8'sd0}, '{8'sd0, -8'sd64, 8'sd0}}
    };

    // One image row, pix[0] is the leftmost pixel
    typedef struct packed {
        logic [IMG_WIDTH-1:0][PIXEL_BITS-1:0] pix;
    } pixel_row_t;

    // One convolution row, val[channel][column]
    typedef struct packed {
        logic [OUT_CHANNELS-1:0][IMG_WIDTH-1:0][PIXEL_BITS-1:0] val;
    } feature_row_t;

    // One pooled row, val[channel][column]
    typedef struct packed {
        logic [OUT_CHANNELS-1:0][POOL_WIDTH-1:0][PIXEL_BITS-1:0] val;
    } pool_row_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_PRIME,
        SEQ_STREAM,
        SEQ_FLUSH
    } seq_state_t;

endpackage

//--- logic/cnn_top.sv
// Top level of the streaming feature extractor, pixels in and pooled feature words out
`timescale 1ns/1ps

module cnn_top (
    input  logic        clock_i,
    input  logic        rst_n_i,
    input  logic [31:0] in_data_i,
    input  logic        in_valid_i,
    output logic        upstream_stall_o,
    output logic [31:0] out_data_o,
    output logic        out_valid_o,
    input  logic        downstream_stall_i
);

    cnn_pkg::pixel_row_t   par_row;
    logic                  par_row_valid;
    logic                  par_row_accept;
    logic                  row_last;
    logic                  conv_load;
    logic                  conv_flush;
    logic                  conv_busy;
    cnn_pkg::feature_row_t conv_row;
    logic                  conv_row_valid;
    logic                  conv_row_accept;
    cnn_pkg::pool_row_t    pool_row;
    logic                  pool_row_valid;
    logic                  pool_row_accept;

    row_parallelize row_parallelize_inst (
        .clock_i(clock_i), .rst_n_i(rst_n_i),
        .in_data_i(in_data_i), .in_valid_i(in_valid_i),
        .upstream_stall_o(upstream_stall_o),
        .row_o(par_row), .row_valid_o(par_row_valid), .row_accept_i(par_row_accept)
    );

    // The load strobe marks each row taken from the parallelizer
    row_counter row_counter_inst (
        .clock_i(clock_i), .rst_n_i(rst_n_i),
        .row_taken_i(conv_load), .row_last_o(row_last)
    );

    conv_sequencer conv_sequencer_inst (
        .clock_i(clock_i), .rst_n_i(rst_n_i),
        .row_valid_i(par_row_valid), .row_last_i(row_last), .out_busy_i(conv_busy),
        .row_accept_o(par_row_accept), .load_o(conv_load), .flush_o(conv_flush)
    );

    conv_row_layer conv_row_layer_inst (
        .clock_i(clock_i), .rst_n_i(rst_n_i),
        .row_i(par_row), .load_i(conv_load), .flush_i(conv_flush), .out_busy_o(conv_busy),
        .out_row_o(conv_row), .out_row_valid_o(conv_row_valid),
        .out_row_accept_i(conv_row_accept)
    );

    max_pool_row max_pool_row_inst (
        .clock_i(clock_i), .rst_n_i(rst_n_i),
        .in_row_i(conv_row), .in_row_valid_i(conv_row_valid),
        .in_row_accept_o(conv_row_accept),
        .out_row_o(pool_row), .out_row_valid_o(pool_row_valid),
        .out_row_accept_i(pool_row_accept)
    );

    row_serialize row_serialize_inst (
        .clock_i(clock_i), .rst_n_i(rst_n_i),
        .in_row_i(pool_row), .in_row_valid_i(pool_row_valid),
        .in_row_accept_o(pool_row_accept),
        .out_data_o(out_data_o), .out_valid_o(out_valid_o),
        .downstream_stall_i(downstream_stall_i)
    );

endmodule

//--- logic/conv_row_layer.sv
// Line buffer and 3x3 two-channel convolution producing one clamped feature row per window
`timescale 1ns/1ps

module conv_row_layer (
    input  logic                  clock_i,
    input  logic                  rst_n_i,
    input  cnn_pkg::pixel_row_t   row_i,
    input  logic                  load_i,
    input  logic                  flush_i,
    output logic                  out_busy_o,
    output cnn_pkg::feature_row_t out_row_o,
    output logic                  out_row_valid_o,
    input  logic                  out_row_accept_i
);

    cnn_pkg::pixel_row_t   prev_q;
    cnn_pkg::pixel_row_t   cur_q;
    cnn_pkg::pixel_row_t   new_row;
    logic                  primed_q;
    logic                  produce;
    logic                  out_valid_q;
    cnn_pkg::feature_row_t out_row_q;
    cnn_pkg::feature_row_t conv_d;
    logic [2:0][cnn_pkg::IMG_WIDTH-1:0][cnn_pkg::PIXEL_BITS-1:0] window;

    assign new_row = flush_i ? '0 : row_i;
    assign produce = flush_i || (load_i && primed_q);

    assign window[0] = prev_q.pix;
    assign window[1] = cur_q.pix;
    assign window[2] = new_row.pix;

    always_comb begin
        int acc;
        int col;
        conv_d = '0;
        for (int ch = 0; ch < cnn_pkg::OUT_CHANNELS; ch++) begin
            for (int x = 0; x < cnn_pkg::IMG_WIDTH; x++) begin
                acc = 0;
                for (int ky = 0; ky < 3; ky++) begin
                    for (int kx = 0; kx < 3; kx++) begin
                        col = x + kx - 1;
                        // Columns outside the row read as zero
                        if (col >= 0 && col < cnn_pkg::IMG_WIDTH) begin
                            acc += int'(cnn_pkg::KERNEL_WEIGHTS[ch][ky][kx])
                                   * int'({1'b0, window[ky][col]});
                        end
                    end
                end
                acc = acc >>> cnn_pkg::WEIGHT_Q_SHIFT;
                // Clamp to pixel range, negative sums give the ReLU
                if (acc < 0) begin
                    conv_d.val[ch][x] = '0;
                end else if (acc > (1 << cnn_pkg::PIXEL_BITS) - 1) begin
                    conv_d.val[ch][x] = '1;
                end else begin
                    conv_d.val[ch][x] = acc[cnn_pkg::PIXEL_BITS-1:0];
                end
            end
        end
    end

    // Line buffer, a load into an empty buffer starts a frame with zero padding above
    always_ff @(posedge clock_i) begin
        if (load_i || flush_i) begin
            prev_q <= primed_q ? cur_q : '0;
            cur_q  <= new_row;
        end
        if (produce) begin
            out_row_q <= conv_d;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            primed_q    <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            if (flush_i) begin
                primed_q <= 1'b0;
            end else if (load_i) begin
                primed_q <= 1'b1;
            end
            if (produce) begin
                out_valid_q <= 1'b1;
            end else if (out_row_accept_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    assign out_row_o       = out_row_q;
    assign out_row_valid_o = out_valid_q;
    assign out_busy_o      = out_valid_q;

endmodule

//--- logic/conv_sequencer.sv
// Frame controller that decides when rows are loaded into the line buffer and when it is flushed
`timescale 1ns/1ps

module conv_sequencer (
    input  logic clock_i,
    input  logic rst_n_i,
    input  logic row_valid_i,
    input  logic row_last_i,
    input  logic out_busy_i,
    output logic row_accept_o,
    output logic load_o,
    output logic flush_o
);

    cnn_pkg::seq_state_t state_q;
    cnn_pkg::seq_state_t state_d;

    always_comb begin
        state_d = state_q;
        load_o  = 1'b0;
        flush_o = 1'b0;
        case (state_q)
            cnn_pkg::SEQ_IDLE: begin
                // First row of a frame only primes the buffer
                if (row_valid_i && !out_busy_i) begin
                    load_o  = 1'b1;
                    state_d = cnn_pkg::SEQ_PRIME;
                end
            end
            cnn_pkg::SEQ_PRIME, cnn_pkg::SEQ_STREAM: begin
                if (row_valid_i && !out_busy_i) begin
                    load_o  = 1'b1;
                    state_d = row_last_i ? cnn_pkg::SEQ_FLUSH : cnn_pkg::SEQ_STREAM;
                end
            end
            cnn_pkg::SEQ_FLUSH: begin
                // Zero row below the last image row
                if (!out_busy_i) begin
                    flush_o = 1'b1;
                    state_d = cnn_pkg::SEQ_IDLE;
                end
            end
            default: state_d = cnn_pkg::SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            state_q <= cnn_pkg::SEQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign row_accept_o = load_o;

endmodule

//--- logic/max_pool_row.sv
// 2x2 max pooling that stores each even feature row and combines it with the following odd row
`timescale 1ns/1ps

module max_pool_row (
    input  logic                  clock_i,
    input  logic                  rst_n_i,
    input  cnn_pkg::feature_row_t in_row_i,
    input  logic                  in_row_valid_i,
    output logic                  in_row_accept_o,
    output cnn_pkg::pool_row_t    out_row_o,
    output logic                  out_row_valid_o,
    input  logic                  out_row_accept_i
);

    cnn_pkg::feature_row_t held_q;
    cnn_pkg::pool_row_t    pool_q;
    cnn_pkg::pool_row_t    pool_d;
    logic                  odd_q;
    logic                  out_valid_q;
    logic                  take;

    // Even rows always fit, odd rows need a free output register
    assign in_row_accept_o = !odd_q || !out_valid_q;
    assign take            = in_row_valid_i && in_row_accept_o;

    always_comb begin
        logic [cnn_pkg::PIXEL_BITS-1:0] top_max;
        logic [cnn_pkg::PIXEL_BITS-1:0] bot_max;
        pool_d = '0;
        for (int ch = 0; ch < cnn_pkg::OUT_CHANNELS; ch++) begin
            for (int x = 0; x < cnn_pkg::POOL_WIDTH; x++) begin
                top_max = (held_q.val[ch][2*x] > held_q.val[ch][2*x+1]) ?
                          held_q.val[ch][2*x] : held_q.val[ch][2*x+1];
                bot_max = (in_row_i.val[ch][2*x] > in_row_i.val[ch][2*x+1]) ?
                          in_row_i.val[ch][2*x] : in_row_i.val[ch][2*x+1];
                pool_d.val[ch][x] = (top_max > bot_max) ? top_max : bot_max;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (take && !odd_q) begin
            held_q <= in_row_i;
        end
        if (take && odd_q) begin
            pool_q <= pool_d;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            odd_q       <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            if (take) begin
                odd_q <= !odd_q;
            end
            if (take && odd_q) begin
                out_valid_q <= 1'b1;
            end else if (out_row_accept_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    assign out_row_o       = pool_q;
    assign out_row_valid_o = out_valid_q;

endmodule

//--- logic/row_counter.sv
// Tracks the image row position within a frame and flags the final row
`timescale 1ns/1ps

module row_counter (
    input  logic clock_i,
    input  logic rst_n_i,
    input  logic row_taken_i,
    output logic row_last_o
);

    logic [2:0] row_idx_q;

    // Wraps to row 0 after the last row of a frame
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            row_idx_q <= '0;
        end else if (row_taken_i) begin
            row_idx_q <= row_idx_q + 3'd1;
        end
    end

    assign row_last_o = (row_idx_q == 3'(cnn_pkg::IMG_WIDTH - 1));

endmodule

//--- logic/row_parallelize.sv
// Gathers streamed pixels into a full image row and holds it until the convolution accepts it
`timescale 1ns/1ps

module row_parallelize (
    input  logic                clock_i,
    input  logic                rst_n_i,
    input  logic [31:0]         in_data_i,
    input  logic                in_valid_i,
    output logic                upstream_stall_o,
    output cnn_pkg::pixel_row_t row_o,
    output logic                row_valid_o,
    input  logic                row_accept_i
);

    logic [2:0]          col_q;
    logic                row_valid_q;
    cnn_pkg::pixel_row_t row_q;
    logic                take_pixel;

    assign take_pixel = in_valid_i && !row_valid_q;

    // Shift from the top so the first pixel lands in column 0
    always_ff @(posedge clock_i) begin
        if (take_pixel) begin
            row_q.pix <= {in_data_i[cnn_pkg::PIXEL_BITS-1:0],
                          row_q.pix[cnn_pkg::IMG_WIDTH-1:1]};
        end
    end

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            col_q       <= '0;
            row_valid_q <= 1'b0;
        end else if (take_pixel) begin
            col_q <= col_q + 3'd1;
            if (col_q == 3'(cnn_pkg::IMG_WIDTH - 1)) begin
                row_valid_q <= 1'b1;
            end
        end else if (row_valid_q && row_accept_i) begin
            row_valid_q <= 1'b0;
        end
    end

    assign row_o            = row_q;
    assign row_valid_o      = row_valid_q;
    assign upstream_stall_o = row_valid_q;

endmodule

//--- logic/row_serialize.sv
// Sends each pooled row as eight channel-major words, holding while the output is stalled
`timescale 1ns/1ps

module row_serialize (
    input  logic               clock_i,
    input  logic               rst_n_i,
    input  cnn_pkg::pool_row_t in_row_i,
    input  logic               in_row_valid_i,
    output logic               in_row_accept_o,
    output logic [31:0]        out_data_o,
    output logic               out_valid_o,
    input  logic               downstream_stall_i
);

    cnn_pkg::pool_row_t row_q;
    logic [2:0]         word_idx_q;
    logic               busy_q;
    logic               load;

    assign in_row_accept_o = !busy_q;
    assign load            = in_row_valid_i && !busy_q;

    always_ff @(posedge clock_i) begin
        if (load) begin
            row_q <= in_row_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            busy_q     <= 1'b0;
            word_idx_q <= '0;
        end else if (load) begin
            busy_q     <= 1'b1;
            word_idx_q <= '0;
        end else if (busy_q && !downstream_stall_i) begin
            word_idx_q <= word_idx_q + 3'd1;
            if (word_idx_q == 3'(cnn_pkg::OUT_CHANNELS * cnn_pkg::POOL_WIDTH - 1)) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Word index is column + channel * POOL_WIDTH
    assign out_data_o  = 32'(row_q.val[word_idx_q / cnn_pkg::POOL_WIDTH]
                                      [word_idx_q % cnn_pkg::POOL_WIDTH]);
    assign out_valid_o = busy_q;

endmodule

//--- verif/cnn_assertions.sv
// Concurrent checks on the stream and row handshakes, bound into cnn_top by the testbench
`timescale 1ns/1ps

module cnn_assertions (
    input logic                clock_i,
    input logic                rst_n_i,
    input logic                in_valid_i,
    input logic                upstream_stall_i,
    input logic [31:0]         out_data_i,
    input logic                out_valid_i,
    input logic                downstream_stall_i,
    input logic                par_row_valid_i,
    input logic                par_row_accept_i,
    input logic                conv_row_valid_i,
    input logic                conv_row_accept_i,
    input logic                pool_row_valid_i,
    input logic                pool_row_accept_i,
    input cnn_pkg::seq_state_t seq_state_i
);

    int         failures = 0;
    logic [2:0] words_in_row_q;

    // Accepted input words within the current row
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            words_in_row_q <= '0;
        end else if (in_valid_i && !upstream_stall_i) begin
            words_in_row_q <= words_in_row_q + 3'd1;
        end
    end

    // Only the eighth accepted word of a row completes it
    assert property (@(posedge clock_i) disable iff (!rst_n_i)
        in_valid_i && !upstream_stall_i
        |=> par_row_valid_i == $past(words_in_row_q == 3'(cnn_pkg::IMG_WIDTH - 1)))
        else begin
            failures++;
            $error("accepted input words do not line up with completed rows");
        end

    assert property (@(posedge clock_i) disable iff (!rst_n_i)
        out_valid_i && downstream_stall_i |=> out_valid_i && $stable(out_data_i))
        else begin
            failures++;
            $error("output changed while stalled");
        end

    assert property (@(posedge clock_i) disable iff (!rst_n_i)
        par_row_valid_i && !par_row_accept_i |=> par_row_valid_i)
        else begin
            failures++;
            $error("pixel row valid dropped before accept");
        end

    assert property (@(posedge clock_i) disable iff (!rst_n_i)
        conv_row_valid_i && !conv_row_accept_i |=> conv_row_valid_i)
        else begin
            failures++;
            $error("feature row valid dropped before accept");
        end

    assert property (@(posedge clock_i) disable iff (!rst_n_i)
        pool_row_valid_i && !pool_row_accept_i |=> pool_row_valid_i)
        else begin
            failures++;
            $error("pooled row valid dropped before accept");
        end

    // Controls are cleared one edge after reset is seen
    assert property (@(posedge clock_i)
        !rst_n_i |=> !out_valid_i && !upstream_stall_i && !par_row_valid_i
                     && !conv_row_valid_i && !pool_row_valid_i
                     && seq_state_i == cnn_pkg::SEQ_IDLE)
        else begin
            failures++;
            $error("controls not idle after reset");
        end

endmodule

//--- verif/cnn_tb.sv
// Directed testbench for cnn_top, run with the file list and the Makefile in the project root
`timescale 1ns/1ps

module cnn_tb;

    localparam int          RESET_CYCLES    = 10;
    localparam int          TOTAL_FRAMES    = 7;
    localparam int          WATCHDOG_CYCLES = TOTAL_FRAMES * 64 * 40;
    localparam int          DRAIN_CYCLES    = 64 * 40;
    localparam int          SETTLE_CYCLES   = 20;
    localparam int          HOLD_CYCLES     = 200;
    localparam logic [31:0] LFSR_SEED       = 32'h4ea8_8245;

    logic        clock            = 1'b0;
    logic        rst_n            = 1'b0;
    logic [31:0] in_data          = '0;
    logic        in_valid         = 1'b0;
    logic        downstream_stall = 1'b0;
    logic        upstream_stall;
    logic [31:0] out_data;
    logic        out_valid;

    logic [31:0] lfsr_state = LFSR_SEED;
    logic [cnn_pkg::PIXEL_BITS-1:0] image [cnn_pkg::IMG_WIDTH][cnn_pkg::IMG_WIDTH];
    logic [cnn_pkg::PIXEL_BITS-1:0] expected_q [$];
    int errors          = 0;
    int checks          = 0;
    int tests_run       = 0;
    int test_error_base = 0;
    int words_planned   = 0;
    int words_received  = 0;
    int stall_run       = 0;
    int longest_stall   = 0;

    cnn_top cnn_top_inst (
        .clock_i(clock), .rst_n_i(rst_n),
        .in_data_i(in_data), .in_valid_i(in_valid), .upstream_stall_o(upstream_stall),
        .out_data_o(out_data), .out_valid_o(out_valid), .downstream_stall_i(downstream_stall)
    );

    bind cnn_top cnn_assertions cnn_assertions_inst (
        .clock_i(clock_i), .rst_n_i(rst_n_i), .in_valid_i(in_valid_i),
        .upstream_stall_i(upstream_stall_o), .out_data_i(out_data_o),
        .out_valid_i(out_valid_o), .downstream_stall_i(downstream_stall_i),
        .par_row_valid_i(par_row_valid), .par_row_accept_i(par_row_accept),
        .conv_row_valid_i(conv_row_valid), .conv_row_accept_i(conv_row_accept),
        .pool_row_valid_i(pool_row_valid), .pool_row_accept_i(pool_row_accept),
        .seq_state_i(conv_sequencer_inst.state_q)
    );

    initial begin
        forever #5 clock = ~clock;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
                 WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    task automatic compare_pixel(input logic [cnn_pkg::PIXEL_BITS-1:0] expected,
                                 input logic [cnn_pkg::PIXEL_BITS-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: out_data_o expected %0d, actual %0d",
                     $time, expected, actual);
        end
    endtask

    task automatic compare_count(input int expected, input int actual);
        checks++;
        if (actual < expected) begin
            errors++;
            $display("Missing output words: %0d of %0d arrived", actual, expected);
        end else if (actual > expected) begin
            errors++;
            $display("Extra output words: %0d arrived where %0d were due", actual, expected);
        end
    endtask

    // Output words and upstream stall length sampled mid-cycle
    always @(negedge clock) begin
        if (rst_n && out_valid && !downstream_stall) begin
            words_received++;
            if (expected_q.size() > 0) begin
                compare_pixel(expected_q.pop_front(), out_data[cnn_pkg::PIXEL_BITS-1:0]);
            end
            if (out_data[31:cnn_pkg::PIXEL_BITS] != '0) begin
                report_failure("output word is not zero-extended");
            end
        end
        stall_run = (rst_n && upstream_stall) ? stall_run + 1 : 0;
        if (stall_run > longest_stall) begin
            longest_stall = stall_run;
        end
    end

    function automatic int pixel_at(input int y, input int x);
        if (y < 0 || y >= cnn_pkg::IMG_WIDTH || x < 0 || x >= cnn_pkg::IMG_WIDTH) begin
            return 0;
        end
        return int'(image[y][x]);
    endfunction

    function automatic int conv_value(input int ch, input int y, input int x);
        int sum;
        sum = 0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                sum += int'(cnn_pkg::KERNEL_WEIGHTS[ch][dy + 1][dx + 1]) * pixel_at(y + dy, x + dx);
            end
        end
        if (sum < 0) begin
            return 0;
        end
        sum = sum / (1 << cnn_pkg::WEIGHT_Q_SHIFT);
        return (sum > 255) ? 255 : sum;
    endfunction

    // Pooled rows in order and channel-major within each row
    task automatic model_frame();
        int best;
        int v;
        for (int py = 0; py < cnn_pkg::IMG_WIDTH / 2; py++) begin
            for (int ch = 0; ch < cnn_pkg::OUT_CHANNELS; ch++) begin
                for (int px = 0; px < cnn_pkg::POOL_WIDTH; px++) begin
                    best = 0;
                    for (int k = 0; k < 4; k++) begin
                        v    = conv_value(ch, 2 * py + k / 2, 2 * px + k % 2);
                        best = (v > best) ? v : best;
                    end
                    expected_q.push_back(best[cnn_pkg::PIXEL_BITS-1:0]);
                    words_planned++;
                end
            end
        end
    endtask

    task automatic fill_uniform(input logic [cnn_pkg::PIXEL_BITS-1:0] value);
        for (int y = 0; y < cnn_pkg::IMG_WIDTH; y++) begin
            for (int x = 0; x < cnn_pkg::IMG_WIDTH; x++) begin
                image[y][x] = value;
            end
        end
    endtask

    task automatic fill_random();
        logic [31:0] bits;
        for (int y = 0; y < cnn_pkg::IMG_WIDTH; y++) begin
            for (int x = 0; x < cnn_pkg::IMG_WIDTH; x++) begin
                bits        = lfsr_bits(cnn_pkg::PIXEL_BITS);
                image[y][x] = bits[cnn_pkg::PIXEL_BITS-1:0];
            end
        end
    endtask

    task automatic apply_reset();
        rst_n            <= 1'b0;
        in_valid         <= 1'b0;
        downstream_stall <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
    endtask

    // Raster order with each word held until the stall is seen low
    task automatic send_pixels(input int count, input bit keep_valid);
        bit taken;
        for (int i = 0; i < count; i++) begin
            in_data  <= 32'(image[i / cnn_pkg::IMG_WIDTH][i % cnn_pkg::IMG_WIDTH]);
            in_valid <= 1'b1;
            taken = 1'b0;
            while (!taken) begin
                @(negedge clock);
                taken = !upstream_stall;
                @(posedge clock);
            end
        end
        if (!keep_valid) begin
            in_valid <= 1'b0;
        end
    endtask

    task automatic start_test();
        expected_q.delete();
        words_planned   = 0;
        words_received  = 0;
        test_error_base = errors;
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        while (expected_q.size() > 0 && waited < DRAIN_CYCLES) begin
            @(posedge clock);
            waited++;
        end
        repeat (SETTLE_CYCLES) @(posedge clock);
        compare_count(words_planned, words_received);
        tests_run++;
        $display("%s: %0d words, %0d errors", name, words_received, errors - test_error_base);
    endtask

    task automatic test_uniform();
        start_test();
        fill_uniform(8'd160);
        model_frame();
        send_pixels(64, 1'b0);
        finish_test("uniform image");
    endtask

    task automatic test_random();
        start_test();
        fill_random();
        model_frame();
        send_pixels(64, 1'b0);
        finish_test("random image");
    endtask

    task automatic test_back_to_back();
        start_test();
        fill_random();
        model_frame();
        send_pixels(64, 1'b1);
        fill_random();
        model_frame();
        send_pixels(64, 1'b0);
        finish_test("back-to-back frames");
    endtask

    task automatic test_output_stall();
        logic [31:0] bits;
        start_test();
        fill_random();
        model_frame();
        longest_stall = 0;
        downstream_stall <= 1'b1;
        fork
            send_pixels(64, 1'b0);
            begin
                // Full stall first and random stall bits after
                repeat (HOLD_CYCLES) @(posedge clock);
                while (expected_q.size() > 0) begin
                    bits = lfsr_bits(1);
                    downstream_stall <= bits[0];
                    @(posedge clock);
                end
                downstream_stall <= 1'b0;
            end
        join
        checks++;
        if (longest_stall < 32) begin
            report_failure("upstream_stall_o did not hold under sustained downstream stall");
        end
        finish_test("output stall");
    endtask

    task automatic test_reset_mid_frame();
        fill_random();
        // Output stalled so rows are in flight and out_valid_o is high when reset arrives
        downstream_stall <= 1'b1;
        send_pixels(60, 1'b0);
        apply_reset();
        start_test();
        @(negedge clock);
        checks++;
        if (out_valid || upstream_stall) begin
            report_failure("out_valid_o or upstream_stall_o high right after reset");
        end
        @(posedge clock);
        fill_random();
        model_frame();
        send_pixels(64, 1'b0);
        finish_test("reset mid-frame");
    endtask

    initial begin
        @(posedge clock);
        apply_reset();
        test_uniform();
        test_random();
        test_back_to_back();
        test_output_stall();
        test_reset_mid_frame();
        errors += cnn_top_inst.cnn_assertions_inst.failures;
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
